//--- verilog/hmm_consts.svh
`ifndef HMM_CONSTS_SVH
`define HMM_CONSTS_SVH

// ******************************
// column geometry
// ******************************

// states per column
`define HMM_LANES 16

// bits per state score or logpost lane
`define HMM_LANE_W 16

// ******************************
// channel framing
// ******************************

`define HMM_BEAT_W 128          // riffa data width
`define HMM_LANES_PER_BEAT 8    // lanes packed per 128-bit beat
`define HMM_BEATS_PER_VEC 2     // beats for a full lane vector

// 32-bit words per beat, scales CHNL_TX_LEN
`define HMM_WORDS_PER_BEAT 4

`endif

//--- verilog/hmm_pkg.sv
`include "hmm_consts.svh"

package hmm_pkg;

        // ******************************
        // lane payloads
        // ******************************
        typedef logic [`HMM_LANE_W-1:0] score_t;      // wraps mod 2^16
        typedef logic [`HMM_LANE_W-1:0] logpost_t;

        // lane 0 sits in the low word
        typedef score_t [`HMM_LANES-1:0] score_vec_t;

        typedef logic [3:0] lane_idx_t;               // 16 lanes

        // ******************************
        // channel side
        // ******************************
        typedef logic [31:0] col_cnt_t;               // from the header beat
        typedef logic [31:0] tx_len_t;                // in 32-bit words

        typedef logic [`HMM_BEAT_W-1:0] beat_t;

endpackage

//--- verilog/lane_bank.sv
`timescale 1ns/1ps

`include "hmm_consts.svh"

module lane_bank #(
        parameter type T = hmm_pkg::score_t
) (
        input  logic                    CLKd,
        input  logic                    RST,
        input  logic                    load,
        input  logic                    beat_sel,
        input  hmm_pkg::beat_t          beat,
        output T [`HMM_LANES-1:0]       lanes
);

        // beat 0 fills lanes 0..7, beat 1 fills lanes 8..15
        always_ff @(posedge CLKd or posedge RST) begin
                if (RST) begin
                        lanes <= '0;
                end else if (load) begin
                        for (int i = 0; i < `HMM_LANES_PER_BEAT; i++) begin
                                if (beat_sel) begin
                                        lanes[`HMM_LANES_PER_BEAT + i] <=
                                                T'(beat[i*`HMM_LANE_W +: `HMM_LANE_W]);
                                end else begin
                                        lanes[i] <= T'(beat[i*`HMM_LANE_W +: `HMM_LANE_W]);
                                end
                        end
                end
        end

endmodule

//--- verilog/column_update.sv
`timescale 1ns/1ps

`include "hmm_consts.svh"

module column_update (
        input  logic                                    CLKd,
        input  logic                                    RST,
        input  logic                                    col_start,
        input  logic                                    first_col,
        input  hmm_pkg::score_t                         stay,
        input  hmm_pkg::score_vec_t                     init_scores,
        input  hmm_pkg::logpost_t [`HMM_LANES-1:0]      logposts,
        output logic                                    res_valid,
        output hmm_pkg::lane_idx_t                      res_idx,
        output hmm_pkg::score_t                         res_score
);

        hmm_pkg::score_vec_t old_vec;
        hmm_pkg::score_vec_t nxt_vec;
        hmm_pkg::score_vec_t cur_vec;   // stage 1 result, old vector of next column
        logic                s1_valid;
        hmm_pkg::lane_idx_t  best_idx;
        hmm_pkg::score_t     best_score;

        assign old_vec = first_col ? init_scores : cur_vec;

        // ******************************
        // stage 1: stay / advance rule
        // ******************************
        always_comb begin : col_rule
                hmm_pkg::score_t stay_sum;
                stay_sum = '0;
                nxt_vec[0] = old_vec[0] + stay + logposts[0];  // lane 0 can only stay
                for (int k = 1; k < `HMM_LANES; k++) begin
                        stay_sum = old_vec[k] + stay;
                        // unsigned compare, sums already wrapped
                        if (stay_sum > old_vec[k-1]) begin
                                nxt_vec[k] = stay_sum + logposts[k];
                        end else begin
                                nxt_vec[k] = old_vec[k-1] + logposts[k];
                        end
                end
        end

        // ******************************
        // stage 2: best lane
        // ******************************
        always_comb begin : pick_best
                best_idx = '0;
                best_score = cur_vec[0];
                for (int k = 1; k < `HMM_LANES; k++) begin
                        if (cur_vec[k] > best_score) begin      // strict, lowest index keeps ties
                                best_idx = hmm_pkg::lane_idx_t'(k);
                                best_score = cur_vec[k];
                        end
                end
        end

        always_ff @(posedge CLKd or posedge RST) begin
                if (RST) begin
                        s1_valid <= 1'b0;
                        res_valid <= 1'b0;
                end else begin
                        s1_valid <= col_start;
                        res_valid <= s1_valid;
                end
        end

        always_ff @(posedge CLKd) begin
                if (col_start) begin
                        cur_vec <= nxt_vec;
                end
                if (s1_valid) begin
                        res_idx <= best_idx;
                        res_score <= best_score;
                end
        end

endmodule

//--- verilog/rx_ctrl.sv
`timescale 1ns/1ps

`include "hmm_consts.svh"

module rx_ctrl (
        input  logic                    CLKd,
        input  logic                    RST,
        input  logic                    CHNL_RX,
        input  logic                    CHNL_RX_LAST,
        input  logic [31:0]             CHNL_RX_LEN,
        input  logic [30:0]             CHNL_RX_OFF,
        input  hmm_pkg::beat_t          CHNL_RX_DATA,
        input  logic                    CHNL_RX_DATA_VALID,
        output logic                    CHNL_RX_ACK,
        output logic                    CHNL_RX_DATA_REN,
        output logic                    init_load,
        output logic                    logpost_load,
        output logic                    beat_sel,
        output hmm_pkg::score_t         stay,
        output hmm_pkg::col_cnt_t       col_count,
        output logic                    hdr_valid,
        output logic                    col_start,
        output logic                    first_col,
        input  logic                    res_taken
);

        // length and offset are ignored, the header beat carries the column count
        typedef enum logic [2:0] {
                st_idle, st_ack, st_hdr, st_init, st_stay, st_lp, st_wait, st_drain
        } rx_state_t;

        rx_state_t          state;
        logic               taken;
        logic               half;               // beat within a lane vector
        logic               last_half;
        logic               first_pend;
        hmm_pkg::col_cnt_t  cols_left;
        hmm_pkg::col_cnt_t  hdr_count;

        assign CHNL_RX_ACK = (state == st_ack);
        assign CHNL_RX_DATA_REN = (state == st_hdr) || (state == st_init) ||
                                  (state == st_stay) || (state == st_lp);
        assign taken = CHNL_RX_DATA_VALID && CHNL_RX_DATA_REN;
        assign last_half = (half == 1'(`HMM_BEATS_PER_VEC - 1));
        assign hdr_count = CHNL_RX_DATA[31:0];

        assign init_load = taken && (state == st_init);
        assign logpost_load = taken && (state == st_lp);
        assign beat_sel = half;

        // ******************************
        // receive FSM
        // ******************************
        always_ff @(posedge CLKd or posedge RST) begin
                if (RST) begin
                        state <= st_idle;
                        half <= 1'b0;
                        first_pend <= 1'b0;
                        cols_left <= '0;
                        hdr_valid <= 1'b0;
                        col_start <= 1'b0;
                        first_col <= 1'b0;
                end else begin
                        hdr_valid <= 1'b0;
                        col_start <= 1'b0;
                        first_col <= 1'b0;
                        case (state)
                        st_idle: if (CHNL_RX) state <= st_ack;
                        st_ack: state <= st_hdr;                // one-cycle ack
                        st_hdr: if (taken) begin
                                cols_left <= hdr_count;
                                hdr_valid <= 1'b1;
                                first_pend <= 1'b1;
                                half <= 1'b0;
                                state <= (hdr_count == '0) ? st_drain : st_init;
                        end
                        st_init: if (taken) begin
                                half <= ~half;
                                if (last_half) state <= st_stay;
                        end
                        st_stay: if (taken) state <= st_lp;
                        st_lp: if (taken) begin
                                half <= ~half;
                                if (last_half) begin
                                        col_start <= 1'b1;      // bank holds both halves now
                                        first_col <= first_pend;
                                        first_pend <= 1'b0;
                                        state <= st_wait;
                                end
                        end
                        st_wait: if (res_taken) begin   // stall until tx has the beat
                                cols_left <= cols_left - 1'b1;
                                state <= (cols_left == 32'd1) ? st_drain : st_stay;
                        end
                        st_drain: if (!CHNL_RX) state <= st_idle;
                        default: state <= st_idle;
                        endcase
                end
        end

        always_ff @(posedge CLKd) begin
                if (taken && (state == st_hdr)) col_count <= hdr_count;
                if (taken && (state == st_stay)) stay <= CHNL_RX_DATA[`HMM_LANE_W-1:0];
        end

endmodule

//--- verilog/tx_ctrl.sv
`timescale 1ns/1ps

`include "hmm_consts.svh"

module tx_ctrl (
        input  logic                    CLKd,
        input  logic                    RST,
        input  logic                    hdr_valid,
        input  hmm_pkg::col_cnt_t       col_count,
        input  logic                    res_valid,
        input  hmm_pkg::lane_idx_t      res_idx,
        input  hmm_pkg::score_t         res_score,
        output logic                    CHNL_TX,
        output logic                    CHNL_TX_DATA_VALID,
        input  logic                    CHNL_TX_ACK,
        input  logic                    CHNL_TX_DATA_REN,
        output hmm_pkg::tx_len_t        CHNL_TX_LEN,
        output hmm_pkg::beat_t          CHNL_TX_DATA,
        output logic                    res_taken
);

        typedef enum logic [1:0] {tx_idle, tx_open, tx_xfer} tx_state_t;

        tx_state_t          state;
        logic               pend;               // a result waits for the host
        logic               beat_done;
        hmm_pkg::col_cnt_t  beats_left;
        hmm_pkg::beat_t     tx_beat;

        assign CHNL_TX = (state != tx_idle);
        assign CHNL_TX_DATA_VALID = (state == tx_xfer) && pend;
        assign CHNL_TX_DATA = tx_beat;
        assign beat_done = CHNL_TX_DATA_VALID && CHNL_TX_DATA_REN;

        always_ff @(posedge CLKd or posedge RST) begin
                if (RST) begin
                        state <= tx_idle;
                        pend <= 1'b0;
                        beats_left <= '0;
                        res_taken <= 1'b0;
                        CHNL_TX_LEN <= '0;
                end else begin
                        res_taken <= beat_done;
                        if (res_valid) pend <= 1'b1;
                        else if (beat_done) pend <= 1'b0;
                        case (state)
                        tx_idle: if (hdr_valid && (col_count != '0)) begin
                                CHNL_TX_LEN <= hmm_pkg::tx_len_t'(col_count * `HMM_WORDS_PER_BEAT);
                                beats_left <= col_count;
                                state <= tx_open;
                        end
                        tx_open: if (CHNL_TX_ACK) state <= tx_xfer;
                        tx_xfer: if (beat_done) begin
                                beats_left <= beats_left - 1'b1;
                                if (beats_left == 32'd1) state <= tx_idle;      // last column out
                        end
                        default: state <= tx_idle;
                        endcase
                end
        end

        // index in 15:0, score in 31:16, rest zero
        always_ff @(posedge CLKd) begin
                if (res_valid) tx_beat <= hmm_pkg::beat_t'({res_score, 16'(res_idx)});
        end

endmodule

//--- verilog/hmm_chnl_top.sv
`timescale 1ns/1ps

`include "hmm_consts.svh"

module hmm_chnl_top (
        input  logic                    CLKd,
        input  logic                    RST,
        output logic                    CHNL_RX_CLK,
        input  logic                    CHNL_RX,
        output logic                    CHNL_RX_ACK,
        input  logic                    CHNL_RX_LAST,
        input  logic [31:0]             CHNL_RX_LEN,
        input  logic [30:0]             CHNL_RX_OFF,
        input  hmm_pkg::beat_t          CHNL_RX_DATA,
        input  logic                    CHNL_RX_DATA_VALID,
        output logic                    CHNL_RX_DATA_REN,
        output logic                    CHNL_TX_CLK,
        output logic                    CHNL_TX,
        input  logic                    CHNL_TX_ACK,
        output logic                    CHNL_TX_LAST,
        output hmm_pkg::tx_len_t        CHNL_TX_LEN,
        output logic [30:0]             CHNL_TX_OFF,
        output hmm_pkg::beat_t          CHNL_TX_DATA,
        output logic                    CHNL_TX_DATA_VALID,
        input  logic                    CHNL_TX_DATA_REN
);

        logic                                   init_load;
        logic                                   logpost_load;
        logic                                   beat_sel;
        logic                                   hdr_valid;
        logic                                   col_start;
        logic                                   first_col;
        logic                                   res_valid;
        logic                                   res_taken;
        hmm_pkg::score_t                        stay;
        hmm_pkg::col_cnt_t                      col_count;
        hmm_pkg::score_vec_t                    init_scores;
        hmm_pkg::logpost_t [`HMM_LANES-1:0]     logposts;
        hmm_pkg::lane_idx_t                     res_idx;
        hmm_pkg::score_t                        res_score;

        // ******************************
        // channel constants
        // ******************************
        assign CHNL_RX_CLK = CLKd;
        assign CHNL_TX_CLK = CLKd;
        assign CHNL_TX_LAST = 1'b1;     // single tx transaction per rx
        assign CHNL_TX_OFF = '0;

        rx_ctrl u_rx (.*);

        lane_bank #(.T(hmm_pkg::score_t)) u_init_bank (
                .CLKd(CLKd), .RST(RST), .load(init_load), .beat_sel(beat_sel),
                .beat(CHNL_RX_DATA), .lanes(init_scores)
        );

        lane_bank #(.T(hmm_pkg::logpost_t)) u_lp_bank (
                .CLKd(CLKd), .RST(RST), .load(logpost_load), .beat_sel(beat_sel),
                .beat(CHNL_RX_DATA), .lanes(logposts)
        );

        column_update u_col (.*);

        tx_ctrl u_tx (.*);

endmodule

//--- verification/hmm_chnl_assert.sv
`timescale 1ns/1ps

module hmm_chnl_assert (
        input logic             CLKd,
        input logic             RST,
        input logic             CHNL_RX_ACK,
        input logic             CHNL_RX_DATA_REN,
        input logic             CHNL_TX_DATA_VALID,
        input logic             CHNL_TX_DATA_REN,
        input hmm_pkg::beat_t   CHNL_TX_DATA,
        input logic             col_start,
        input logic             res_taken
);

        logic res_pend;         // column in flight until tx reads it

        always_ff @(posedge CLKd or posedge RST) begin
                if (RST) res_pend <= 1'b0;
                else if (col_start) res_pend <= 1'b1;
                else if (res_taken) res_pend <= 1'b0;
        end

        // ******************************
        // channel protocol
        // ******************************
        rx_ack_pulse: assert property (@(posedge CLKd) disable iff (RST)
                CHNL_RX_ACK |=> !CHNL_RX_ACK) else $error("rx ack longer than one cycle");
        rx_stall: assert property (@(posedge CLKd) disable iff (RST)
                res_pend |-> !CHNL_RX_DATA_REN) else $error("rx read enabled with result pending");
        tx_hold: assert property (@(posedge CLKd) disable iff (RST)
                CHNL_TX_DATA_VALID && !CHNL_TX_DATA_REN |=>
                CHNL_TX_DATA_VALID && $stable(CHNL_TX_DATA))
                else $error("tx beat changed or dropped before read");
        tx_once: assert property (@(posedge CLKd) disable iff (RST)
                CHNL_TX_DATA_VALID && CHNL_TX_DATA_REN |=> !CHNL_TX_DATA_VALID)
                else $error("tx beat offered again after read");

endmodule

//--- verification/tb_hmm_chnl.sv
`timescale 1ns/1ps

`include "hmm_consts.svh"

module tb_hmm_chnl;

        localparam int N_ROWS = 6;
        localparam int MAX_COLS = 8;

        typedef enum logic [1:0] {row_peak, row_tie, row_flat, row_rand} row_kind_t;

        typedef struct packed {
                row_kind_t              kind;
                logic [7:0]             n_cols;
                hmm_pkg::score_t        stay;
                hmm_pkg::lane_idx_t     lane;           // directed logpost lane
                hmm_pkg::score_t        value;          // directed logpost value
                hmm_pkg::lane_idx_t     exp_idx;
                hmm_pkg::score_t        exp_score;
        } txn_row_t;

        logic CLKd, RST, CHNL_RX, CHNL_RX_LAST, CHNL_RX_DATA_VALID, CHNL_TX_ACK, CHNL_TX_DATA_REN;
        logic CHNL_RX_CLK, CHNL_RX_ACK, CHNL_RX_DATA_REN, CHNL_TX_CLK, CHNL_TX, CHNL_TX_LAST;
        logic CHNL_TX_DATA_VALID;
        logic [31:0] CHNL_RX_LEN;
        logic [30:0] CHNL_RX_OFF, CHNL_TX_OFF;
        hmm_pkg::beat_t CHNL_RX_DATA, CHNL_TX_DATA;
        hmm_pkg::tx_len_t CHNL_TX_LEN;

        txn_row_t table_rows [N_ROWS];
        hmm_pkg::score_t init_vec [`HMM_LANES];
        hmm_pkg::score_t col_stay [MAX_COLS];
        hmm_pkg::logpost_t col_lp [MAX_COLS][`HMM_LANES];
        hmm_pkg::lane_idx_t exp_idx_q [$];
        hmm_pkg::score_t exp_score_q [$];
        integer seed = 36857;
        int cycles = 0;
        int cycle_limit = 1000;

        hmm_chnl_top u_dut (.*);

        bind hmm_chnl_top hmm_chnl_assert u_assert (.*);

        initial begin
                CLKd = 1'b0;
                forever #4 CLKd = ~CLKd;
        end

        always @(posedge CLKd) begin
                cycles <= cycles + 1;
                if (cycles > cycle_limit) begin
                        $display("Timeout: table not finished after %0d cycles", cycles);
                        $display("Errors found");
                        $fatal(1, "watchdog expired");
                end
        end

        task automatic fail_now(input string why);
                $display("%s", why);
                $display("Errors found");
                $fatal(1, "stopped at first error");
        endtask

        task automatic check_score(input string name, input hmm_pkg::score_t got,
                                   input hmm_pkg::score_t exp);
                if (got !== exp)
                        fail_now($sformatf("** Error: %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_idx(input string name, input hmm_pkg::lane_idx_t got,
                                 input hmm_pkg::lane_idx_t exp);
                if (got !== exp)
                        fail_now($sformatf("** Error: %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_len(input string name, input hmm_pkg::tx_len_t got,
                                 input hmm_pkg::tx_len_t exp);
                if (got !== exp)
                        fail_now($sformatf("** Error: %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_beat(input string name, input hmm_pkg::beat_t got,
                                  input hmm_pkg::beat_t exp);
                if (got !== exp)
                        fail_now($sformatf("** Error: %s got %h expected %h", name, got, exp));
        endtask

        // both channel clocks are plain copies of CLKd
        task automatic compare_chnl_clocks();
                @(posedge CLKd);
                #2;     // mid high phase
                if (CHNL_RX_CLK !== 1'b1 || CHNL_TX_CLK !== 1'b1)
                        fail_now("CHNL_RX_CLK or CHNL_TX_CLK is low while CLKd is high");
                @(negedge CLKd);
                #2;
                if (CHNL_RX_CLK !== 1'b0 || CHNL_TX_CLK !== 1'b0)
                        fail_now("CHNL_RX_CLK or CHNL_TX_CLK is high while CLKd is low");
        endtask

        function automatic hmm_pkg::beat_t pack_lanes(input hmm_pkg::score_t v [`HMM_LANES],
                                                      input int half);
                hmm_pkg::beat_t b;
                b = '0;
                for (int i = 0; i < `HMM_LANES_PER_BEAT; i++) begin
                        b[i*`HMM_LANE_W +: `HMM_LANE_W] = v[half*`HMM_LANES_PER_BEAT + i];
                end
                return b;
        endfunction

        // ******************************
        // reference model of the column rule
        // ******************************
        task automatic model_expect(input int n);
                hmm_pkg::score_t old_v [`HMM_LANES];
                hmm_pkg::score_t new_v [`HMM_LANES];
                hmm_pkg::score_t via_stay;
                hmm_pkg::score_t best;
                hmm_pkg::lane_idx_t best_k;
                old_v = init_vec;
                for (int c = 0; c < n; c++) begin
                        new_v[0] = old_v[0] + col_stay[c] + col_lp[c][0];
                        for (int k = 1; k < `HMM_LANES; k++) begin
                                via_stay = old_v[k] + col_stay[c];      // wraps at 16 bits
                                new_v[k] = ((via_stay > old_v[k-1]) ? via_stay : old_v[k-1])
                                           + col_lp[c][k];
                        end
                        best_k = '0;
                        best = new_v[0];
                        for (int k = 1; k < `HMM_LANES; k++) begin
                                if (new_v[k] > best) begin
                                        best_k = hmm_pkg::lane_idx_t'(k);
                                        best = new_v[k];
                                end
                        end
                        exp_idx_q.push_back(best_k);
                        exp_score_q.push_back(best);
                        old_v = new_v;
                end
        endtask

        task automatic build_row(input txn_row_t r);
                for (int k = 0; k < `HMM_LANES; k++) begin
                        init_vec[k] = (r.kind == row_rand) ? hmm_pkg::score_t'($random(seed)) : '0;
                end
                for (int c = 0; c < int'(r.n_cols); c++) begin
                        col_stay[c] = (r.kind == row_rand) ?
                                      (hmm_pkg::score_t'($random(seed)) | 16'h0001) : r.stay;
                        for (int k = 0; k < `HMM_LANES; k++) begin
                                case (r.kind)
                                row_peak: col_lp[c][k] = (k == int'(r.lane)) ? r.value : '0;
                                row_tie: col_lp[c][k] = (k == int'(r.lane) || k == `HMM_LANES-1) ?
                                                        r.value : '0;
                                row_flat: col_lp[c][k] = r.value;
                                default: col_lp[c][k] = hmm_pkg::logpost_t'($random(seed));
                                endcase
                        end
                end
                if (r.kind == row_rand) begin
                        model_expect(int'(r.n_cols));
                end else begin
                        exp_idx_q.push_back(r.exp_idx);
                        exp_score_q.push_back(r.exp_score);
                end
        endtask

        // ******************************
        // channel drivers
        // ******************************
        task automatic send_beat(input hmm_pkg::beat_t b);
                CHNL_RX_DATA = b;
                CHNL_RX_DATA_VALID = 1'b1;
                while (!CHNL_RX_DATA_REN) @(negedge CLKd);
                @(negedge CLKd);        // taken on the edge in between
                CHNL_RX_DATA_VALID = 1'b0;
        endtask

        task automatic run_rx(input int n);
                @(negedge CLKd);
                CHNL_RX = 1'b1;
                CHNL_RX_LEN = 32'((3 + 3*n) * `HMM_WORDS_PER_BEAT);
                while (!CHNL_RX_ACK) @(negedge CLKd);
                @(negedge CLKd);
                if (CHNL_RX_ACK) fail_now("CHNL_RX_ACK stayed high for more than one cycle");
                send_beat(hmm_pkg::beat_t'(n));
                send_beat(pack_lanes(init_vec, 0));
                send_beat(pack_lanes(init_vec, 1));
                for (int c = 0; c < n; c++) begin
                        send_beat(hmm_pkg::beat_t'(col_stay[c]));
                        send_beat(pack_lanes(col_lp[c], 0));
                        send_beat(pack_lanes(col_lp[c], 1));
                end
                CHNL_RX = 1'b0;
        endtask

        task automatic run_tx(input int n);
                hmm_pkg::beat_t held;
                int stretch;
                while (!CHNL_TX) @(negedge CLKd);
                check_len("CHNL_TX_LEN", CHNL_TX_LEN, hmm_pkg::tx_len_t'(n * `HMM_WORDS_PER_BEAT));
                if (CHNL_TX_LAST !== 1'b1 || CHNL_TX_OFF !== '0)
                        fail_now("CHNL_TX_LAST or CHNL_TX_OFF is not at its tied value");
                CHNL_TX_ACK = 1'b1;
                @(negedge CLKd);
                CHNL_TX_ACK = 1'b0;
                for (int b = 0; b < n; b++) begin
                        while (!CHNL_TX_DATA_VALID) @(negedge CLKd);
                        held = CHNL_TX_DATA;
                        stretch = $random(seed) & 7;    // host busy for a while
                        repeat (stretch) begin
                                @(negedge CLKd);
                                if (!CHNL_TX_DATA_VALID)
                                        fail_now("CHNL_TX_DATA_VALID dropped before the read");
                                check_beat("CHNL_TX_DATA", CHNL_TX_DATA, held);
                        end
                        CHNL_TX_DATA_REN = 1'b1;
                        @(negedge CLKd);
                        CHNL_TX_DATA_REN = 1'b0;
                        check_idx("CHNL_TX_DATA[3:0]", held[3:0], exp_idx_q.pop_front());
                        check_score("CHNL_TX_DATA[31:16]", held[31:16], exp_score_q.pop_front());
                        if (held[127:32] != '0 || held[15:4] != '0)
                                fail_now($sformatf("** Error: CHNL_TX_DATA pad got %h expected 0",
                                                   {held[127:32], held[15:4]}));
                        if (CHNL_TX_DATA_VALID) fail_now("column beat offered a second time");
                end
                if (CHNL_TX) fail_now("CHNL_TX still high after the last column beat");
        endtask

        initial begin
                {CHNL_RX, CHNL_RX_LAST, CHNL_RX_DATA_VALID, CHNL_TX_ACK, CHNL_TX_DATA_REN} = '0;
                CHNL_RX_LEN = '0;
                CHNL_RX_OFF = '0;
                CHNL_RX_DATA = '0;
                RST = 1'b1;
                // kind, N, stay, lane, value, best index, best score
                table_rows[0] = '{row_peak, 8'd1, 16'h0000, 4'd9, 16'h0123, 4'd9, 16'h0123};
                table_rows[1] = '{row_tie, 8'd1, 16'h0000, 4'd3, 16'h0800, 4'd3, 16'h0800};
                table_rows[2] = '{row_flat, 8'd1, 16'h0005, 4'd0, 16'h0007, 4'd0, 16'h000c};
                table_rows[3] = '{row_rand, 8'd5, 16'h0000, 4'd0, 16'h0000, 4'd0, 16'h0000};
                table_rows[4] = '{row_rand, 8'd8, 16'h0000, 4'd0, 16'h0000, 4'd0, 16'h0000};
                table_rows[5] = '{row_rand, 8'd3, 16'h0000, 4'd0, 16'h0000, 4'd0, 16'h0000};
                cycle_limit = 40;
                for (int r = 0; r < N_ROWS; r++) begin
                        cycle_limit += 40 + 24 * int'(table_rows[r].n_cols);
                end
                repeat (16) @(negedge CLKd);
                RST = 1'b0;
                @(negedge CLKd);
                if (CHNL_RX_ACK || CHNL_RX_DATA_REN || CHNL_TX || CHNL_TX_DATA_VALID)
                        fail_now("a channel control output is high after reset");
                compare_chnl_clocks();
                for (int r = 0; r < N_ROWS; r++) begin
                        build_row(table_rows[r]);
                        fork
                                run_rx(int'(table_rows[r].n_cols));
                                run_tx(int'(table_rows[r].n_cols));
                        join
                        repeat (3) @(negedge CLKd);     // rx drains back to idle
                end
                $display("No errors");
                $finish;
        end

endmodule

//--- sources.f
+incdir+verilog
verilog/hmm_pkg.sv
verilog/lane_bank.sv
verilog/column_update.sv
verilog/rx_ctrl.sv
verilog/tx_ctrl.sv
verilog/hmm_chnl_top.sv
verification/hmm_chnl_assert.sv
verification/tb_hmm_chnl.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_hmm_chnl \
        -f sources.f -o tb_hmm_chnl
./obj_dir/tb_hmm_chnl > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
        echo "simulation passed"
else
        echo "simulation failed"
        exit 1
fi
